// File: common/ipod_consts.svh
`ifndef IPOD_CONSTS_SVH
`define IPOD_CONSTS_SVH

// ====================================================================
// PS/2 set 2 make codes
// ====================================================================
`define SCAN_PLAY     8'h24
`define SCAN_STOP     8'h23
`define SCAN_FORWARD  8'h2B
`define SCAN_BACKWARD 8'h32
`define SCAN_RESTART  8'h2D

// Flash geometry, word addressed
`define FLASH_ADDR_W    23
`define FLASH_LAST_WORD 23'h7FFFF

// ====================================================================
// Sample rate divider
// ====================================================================
// Six hex digits on the display
`define DIV_W       24
// Roughly 44 kHz from 50 MHz
`define DIV_DEFAULT 24'd1136
`define DIV_MIN     24'd64
`define DIV_MAX     24'd4096
`define SPEED_STEP  24'd16

// Short repeat period for simulation
// A board build needs about 5000000 for ten events per second
`define KEY_REPEAT_CYCLES 100

`endif

// File: common/ipod_pkg.sv
`default_nettype none

package ipod_pkg;

  // ====================================================================
  // Keyboard commands and player state
  // ====================================================================

  typedef enum logic [2:0] {
    cmd_none,
    cmd_play,
    cmd_stop,
    cmd_forward,
    cmd_backward,
    cmd_restart
  } command_t;

  typedef enum logic {
    st_stopped,
    st_playing
  } player_state_t;

  // Flash read sequencer
  typedef enum logic [1:0] {
    fetch_idle,
    fetch_request,
    fetch_wait
  } fetch_state_t;

  // ====================================================================
  // Audio data
  // ====================================================================

  typedef logic signed [15:0] sample_t;

  // Low half is the earlier sample when playing forward
  typedef logic [31:0] flash_word_t;

endpackage

`default_nettype wire

// File: player/player_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "ipod_consts.svh"

module player_control
  import ipod_pkg::*;
(
  input  logic       CLK_50M,
  input  logic       rst,
  input  logic [7:0] scan_code,
  input  logic       scan_valid,
  output logic       play,
  output logic       forward,
  output logic       restart_pulse
);

  command_t      cmd;
  player_state_t state;

  // Scan code to command, only while the strobe is up
  always_comb
  begin
    cmd = cmd_none;
    if (scan_valid)
    begin
      case (scan_code)
        `SCAN_PLAY:     cmd = cmd_play;
        `SCAN_STOP:     cmd = cmd_stop;
        `SCAN_FORWARD:  cmd = cmd_forward;
        `SCAN_BACKWARD: cmd = cmd_backward;
        `SCAN_RESTART:  cmd = cmd_restart;
        default:        cmd = cmd_none;
      endcase
    end
  end

  // Play state, direction and the restart strobe
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      state         <= st_stopped;
      forward       <= 1'b1;
      restart_pulse <= 1'b0;
    end
    else
    begin
      restart_pulse <= (cmd == cmd_restart);
      case (cmd)
        cmd_play:     state   <= st_playing;
        cmd_stop:     state   <= st_stopped;
        cmd_forward:  forward <= 1'b1;
        cmd_backward: forward <= 1'b0;
        default:      ;
      endcase
    end
  end

  assign play = (state == st_playing);

  // Restart reaches the fetcher as a single-cycle strobe
  a_restart_single: assert property (@(posedge CLK_50M) disable iff (rst)
    restart_pulse |=> !restart_pulse);

endmodule

`default_nettype wire

// File: player/sample_fetcher.sv
`timescale 1ns/1ps
`default_nettype none

`include "ipod_consts.svh"

module sample_fetcher
  import ipod_pkg::*;
(
  input  logic                     CLK_50M,
  input  logic                     rst,
  input  logic                     play,
  input  logic                     forward,
  input  logic                     restart_pulse,
  input  logic [`DIV_W-1:0]        sample_div,
  output logic                     flash_read,
  output logic [`FLASH_ADDR_W-1:0] flash_address,
  input  logic                     flash_waitrequest,
  input  flash_word_t              flash_readdata,
  input  logic                     flash_readdatavalid,
  output sample_t                  audio_sample,
  output logic                     audio_valid
);

  logic [`DIV_W-1:0]        tick_cnt;
  logic                     tick;
  fetch_state_t             fetch_state;
  logic                     issue;
  logic                     discard;
  logic                     restart_req;
  logic [`FLASH_ADDR_W-1:0] word_addr;
  logic [`FLASH_ADDR_W-1:0] step_addr;
  flash_word_t              word_buf;
  logic                     buf_valid;
  logic                     half_sel;
  logic                     half_used;

  // ====================================================================
  // Sample rate tick
  // ====================================================================
  assign tick = play && (tick_cnt >= sample_div - 1'b1);

  always_ff @(posedge CLK_50M)
  begin
    if (rst || !play || tick)
      tick_cnt <= '0;
    else
      tick_cnt <= tick_cnt + 1'b1;
  end

  // ====================================================================
  // Flash read sequencer
  // ====================================================================
  // Next word in the current direction wraps at both ends
  always_comb
  begin
    if (forward)
      step_addr = (word_addr == `FLASH_LAST_WORD) ? '0 : word_addr + 1'b1;
    else
      step_addr = (word_addr == '0) ? `FLASH_LAST_WORD : word_addr - 1'b1;
  end

  assign issue = (fetch_state == fetch_idle) && !buf_valid && (play || restart_req)
                 && !restart_pulse;
  assign flash_read = (fetch_state == fetch_request);

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      fetch_state <= fetch_idle;
      discard     <= 1'b0;
    end
    else
    begin
      case (fetch_state)
        fetch_idle:    if (issue) fetch_state <= fetch_request;
        fetch_request: if (!flash_waitrequest) fetch_state <= fetch_wait;
        fetch_wait:    if (flash_readdatavalid) fetch_state <= fetch_idle;
        default:       fetch_state <= fetch_idle;
      endcase
      // Data of a read in flight at restart belongs to the old position
      if (restart_pulse && (fetch_state != fetch_idle) && !flash_readdatavalid)
        discard <= 1'b1;
      else if (flash_readdatavalid)
        discard <= 1'b0;
    end
  end

  // Address stays put for the whole request
  always_ff @(posedge CLK_50M)
  begin
    if (issue)
      flash_address <= word_addr;
  end

  // ====================================================================
  // Word buffer and half select
  // ====================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      buf_valid   <= 1'b0;
      half_sel    <= 1'b0;
      half_used   <= 1'b0;
      word_addr   <= '0;
      restart_req <= 1'b0;
      audio_valid <= 1'b0;
    end
    else
    begin
      audio_valid <= tick && buf_valid;
      if (issue)
        restart_req <= 1'b0;
      if (flash_readdatavalid && !discard)
      begin
        buf_valid <= 1'b1;
        half_sel  <= !forward;
        half_used <= 1'b0;
      end
      else if (tick && buf_valid)
      begin
        half_sel  <= !half_sel;
        half_used <= 1'b1;
        // Both halves gone so step on in the direction now set
        if (half_used)
        begin
          buf_valid <= 1'b0;
          half_used <= 1'b0;
          word_addr <= step_addr;
        end
      end
      if (restart_pulse)
      begin
        buf_valid   <= 1'b0;
        half_used   <= 1'b0;
        restart_req <= 1'b1;
        word_addr   <= forward ? '0 : `FLASH_LAST_WORD;
      end
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (flash_readdatavalid && !discard)
      word_buf <= flash_readdata;
    if (tick && buf_valid)
      audio_sample <= half_sel ? word_buf[31:16] : word_buf[15:0];
  end

  // Returned data never meets a newly raised request
  a_one_outstanding: assert property (@(posedge CLK_50M) disable iff (rst)
    flash_readdatavalid |-> !flash_read);

endmodule

`default_nettype wire

// File: verilog/speed_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "ipod_consts.svh"

module speed_control
(
  input  logic              CLK_50M,
  input  logic              rst,
  input  logic [2:0]        key_n,
  output logic [`DIV_W-1:0] sample_div
);

  localparam int REPEAT_W = $clog2(`KEY_REPEAT_CYCLES);

  logic [2:0]          key_meta;
  logic [2:0]          key_sync;
  logic [REPEAT_W-1:0] repeat_cnt;
  logic                repeat_wrap;
  logic [2:0]          key_event;

  assign repeat_wrap = (repeat_cnt == REPEAT_W'(`KEY_REPEAT_CYCLES - 1));

  // Two-stage sync, buttons turned active high
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      key_meta   <= '0;
      key_sync   <= '0;
      repeat_cnt <= '0;
      key_event  <= '0;
    end
    else
    begin
      key_meta   <= ~key_n;
      key_sync   <= key_meta;
      repeat_cnt <= repeat_wrap ? '0 : repeat_cnt + 1'b1;
      key_event  <= repeat_wrap ? key_sync : 3'b000;
    end
  end

  // Divider register, reset button wins
  always_ff @(posedge CLK_50M)
  begin
    if (rst || key_event[2])
      sample_div <= `DIV_DEFAULT;
    else if (key_event[0])
      sample_div <= (sample_div < `DIV_MIN + `SPEED_STEP) ? `DIV_MIN : sample_div - `SPEED_STEP;
    else if (key_event[1])
      sample_div <= (sample_div > `DIV_MAX - `SPEED_STEP) ? `DIV_MAX : sample_div + `SPEED_STEP;
  end

  a_div_range: assert property (@(posedge CLK_50M) disable iff (rst)
    (sample_div >= `DIV_MIN) && (sample_div <= `DIV_MAX));

endmodule

`default_nettype wire

// File: verilog/hex_display.sv
`timescale 1ns/1ps
`default_nettype none

`include "ipod_consts.svh"

module hex_display
(
  input  logic              CLK_50M,
  input  logic              rst,
  input  logic [`DIV_W-1:0] value,
  output logic [6:0]        hex0,
  output logic [6:0]        hex1,
  output logic [6:0]        hex2,
  output logic [6:0]        hex3,
  output logic [6:0]        hex4,
  output logic [6:0]        hex5
);

  // Active low, segment a in bit 0
  function automatic logic [6:0] seg_decode(input logic [3:0] nibble);
    case (nibble)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h10;
      4'hA: return 7'h08;
      4'hB: return 7'h03;
      4'hC: return 7'h46;
      4'hD: return 7'h21;
      4'hE: return 7'h06;
      default: return 7'h0E;
    endcase
  endfunction

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      // All segments dark
      {hex5, hex4, hex3, hex2, hex1, hex0} <= '1;
    end
    else
    begin
      hex0 <= seg_decode(value[3:0]);
      hex1 <= seg_decode(value[7:4]);
      hex2 <= seg_decode(value[11:8]);
      hex3 <= seg_decode(value[15:12]);
      hex4 <= seg_decode(value[19:16]);
      hex5 <= seg_decode(value[23:20]);
    end
  end

endmodule

`default_nettype wire

// File: verilog/ipod_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ipod_consts.svh"

module ipod_top
  import ipod_pkg::*;
(
  input  logic                     CLK_50M,
  input  logic                     rst,
  input  logic [7:0]               scan_code,
  input  logic                     scan_valid,
  input  logic [2:0]               key_n,
  output logic                     flash_read,
  output logic [`FLASH_ADDR_W-1:0] flash_address,
  input  logic                     flash_waitrequest,
  input  flash_word_t              flash_readdata,
  input  logic                     flash_readdatavalid,
  output sample_t                  audio_sample,
  output logic                     audio_valid,
  output logic [6:0]               hex0,
  output logic [6:0]               hex1,
  output logic [6:0]               hex2,
  output logic [6:0]               hex3,
  output logic [6:0]               hex4,
  output logic [6:0]               hex5
);

  logic              play;
  logic              forward;
  logic              restart_pulse;
  logic [`DIV_W-1:0] sample_div;

  // ====================================================================
  // Keyboard commands and playback
  // ====================================================================
  player_control u_player_control (
    .CLK_50M       (CLK_50M),
    .rst           (rst),
    .scan_code     (scan_code),
    .scan_valid    (scan_valid),
    .play          (play),
    .forward       (forward),
    .restart_pulse (restart_pulse)
  );

  sample_fetcher u_sample_fetcher (
    .CLK_50M             (CLK_50M),
    .rst                 (rst),
    .play                (play),
    .forward             (forward),
    .restart_pulse       (restart_pulse),
    .sample_div          (sample_div),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .audio_sample        (audio_sample),
    .audio_valid         (audio_valid)
  );

  // ====================================================================
  // Speed buttons and divider display
  // ====================================================================
  speed_control u_speed_control (
    .CLK_50M    (CLK_50M),
    .rst        (rst),
    .key_n      (key_n),
    .sample_div (sample_div)
  );

  hex_display u_hex_display (
    .CLK_50M (CLK_50M),
    .rst     (rst),
    .value   (sample_div),
    .hex0    (hex0),
    .hex1    (hex1),
    .hex2    (hex2),
    .hex3    (hex3),
    .hex4    (hex4),
    .hex5    (hex5)
  );

endmodule

`default_nettype wire

// File: verification/ipod_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ipod_consts.svh"

module ipod_tb
  import ipod_pkg::*;
();

  localparam int sample_cycles = `DIV_DEFAULT;
  localparam int key_cycles = `KEY_REPEAT_CYCLES;
  localparam int min_cycles = `DIV_MIN;
  // Summed test limits in clock cycles
  localparam int test_cycles = 50 + 10 * sample_cycles + 16 * sample_cycles
                               + 220 * key_cycles + 85 * key_cycles + 40 * min_cycles;
  localparam int watchdog_cycles = test_cycles + 5000;

  // Active low with segment a in bit 0
  localparam logic [6:0] seg_table [16] = '{
    7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
    7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
    7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
    7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
  };

  logic                     CLK_50M = 1'b0;
  logic                     rst = 1'b1;
  logic [7:0]               scan_code = 8'h00;
  logic                     scan_valid = 1'b0;
  logic [2:0]               key_n = 3'b111;
  logic                     flash_read;
  logic [`FLASH_ADDR_W-1:0] flash_address;
  logic                     flash_waitrequest = 1'b1;
  flash_word_t              flash_readdata = '0;
  logic                     flash_readdatavalid = 1'b0;
  sample_t                  audio_sample;
  logic                     audio_valid;
  logic [6:0]               hex0;
  logic [6:0]               hex1;
  logic [6:0]               hex2;
  logic [6:0]               hex3;
  logic [6:0]               hex4;
  logic [6:0]               hex5;

  integer                   seed = 60119;
  int                       lat_cnt = 0;
  logic [`FLASH_ADDR_W-1:0] req_addr = '0;
  int                       cycle_cnt = 0;
  int                       errors = 0;
  int                       checks = 0;
  sample_t                  sample_q [$];
  int                       time_q [$];

  ipod_top u_ipod_top (
    .CLK_50M             (CLK_50M),
    .rst                 (rst),
    .scan_code           (scan_code),
    .scan_valid          (scan_valid),
    .key_n               (key_n),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .audio_sample        (audio_sample),
    .audio_valid         (audio_valid),
    .hex0                (hex0),
    .hex1                (hex1),
    .hex2                (hex2),
    .hex3                (hex3),
    .hex4                (hex4),
    .hex5                (hex5)
  );

  initial
  begin
    forever #10 CLK_50M = ~CLK_50M;
  end

  // ====================================================================
  // Flash model and sample monitor
  // ====================================================================
  // Random stalls and data back 2 to 5 cycles after the accept
  always @(posedge CLK_50M)
  begin
    flash_waitrequest   <= (($random(seed) & 3) == 0);
    flash_readdatavalid <= 1'b0;
    if (lat_cnt == 1)
    begin
      flash_readdatavalid <= 1'b1;
      flash_readdata      <= {req_addr[15:0], ~req_addr[15:0]};
    end
    if (lat_cnt > 0)
      lat_cnt <= lat_cnt - 1;
    else if (flash_read && !flash_waitrequest && !rst)
    begin
      req_addr <= flash_address;
      lat_cnt  <= 2 + ($random(seed) & 3);
    end
  end

  always @(posedge CLK_50M)
  begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // Samples picked up mid-cycle
  always @(negedge CLK_50M)
  begin
    if (audio_valid)
    begin
      sample_q.push_back(audio_sample);
      time_q.push_back(cycle_cnt);
    end
  end

  // High half holds the low address bits and low half their inverse
  function automatic sample_t expected_sample(input logic [`FLASH_ADDR_W-1:0] addr,
                                              input bit high);
    return high ? addr[15:0] : ~addr[15:0];
  endfunction

  function automatic logic [41:0] display_pattern(input logic [`DIV_W-1:0] value);
    logic [41:0] pattern;
    for (int i = 0; i < 6; i++)
      pattern[i*7 +: 7] = seg_table[value[i*4 +: 4]];
    return pattern;
  endfunction

  // ====================================================================
  // Helper tasks
  // ====================================================================
  task automatic send_scan(input logic [7:0] code);
    @(posedge CLK_50M);
    scan_code  <= code;
    scan_valid <= 1'b1;
    @(posedge CLK_50M);
    scan_valid <= 1'b0;
  endtask

  task automatic clear_samples();
    sample_q.delete();
    time_q.delete();
  endtask

  task automatic check_display(input logic [`DIV_W-1:0] value);
    @(negedge CLK_50M);
    checks++;
    assert ({hex5, hex4, hex3, hex2, hex1, hex0} == display_pattern(value))
    else
    begin
      $display("Mismatch at time %0t: display for %h expected %h got %h", $time, value,
               display_pattern(value), {hex5, hex4, hex3, hex2, hex1, hex0});
      errors++;
    end
  endtask

  // Poll until the display shows value or until it leaves it
  task automatic wait_display(input logic [`DIV_W-1:0] value, input bit equal,
                              input int limit);
    int n;
    n = 0;
    @(negedge CLK_50M);
    while ((({hex5, hex4, hex3, hex2, hex1, hex0} == display_pattern(value)) != equal)
           && (n < limit))
    begin
      @(negedge CLK_50M);
      n++;
    end
    checks++;
    assert (n < limit)
    else
    begin
      $display("Error at time %0t: display did not %s %h within %0d cycles", $time,
               equal ? "reach" : "leave", value, limit);
      errors++;
    end
  endtask

  task automatic wait_samples(input int count, input int limit);
    int n;
    n = 0;
    while ((sample_q.size() < count) && (n < limit))
    begin
      @(negedge CLK_50M);
      n++;
    end
    checks++;
    assert (sample_q.size() >= count)
    else
    begin
      $display("Error at time %0t: only %0d of %0d samples arrived within %0d cycles",
               $time, sample_q.size(), count, limit);
      errors++;
    end
  endtask

  task automatic check_sample(input int idx, input logic [`FLASH_ADDR_W-1:0] addr,
                              input bit high);
    sample_t expected;
    sample_t actual;
    expected = expected_sample(addr, high);
    actual = (idx < sample_q.size()) ? sample_q[idx] : '0;
    checks++;
    assert (actual == expected)
    else
    begin
      $display("Mismatch at time %0t: sample %0d expected %h got %h", $time, idx,
               expected, actual);
      errors++;
    end
  endtask

  // ====================================================================
  // Directed tests
  // ====================================================================
  task automatic test_reset();
    check_display(`DIV_DEFAULT);
    repeat (20)
    begin
      @(negedge CLK_50M);
      checks++;
      assert (!flash_read && !audio_valid)
      else
      begin
        $display("Error at time %0t: flash read or audio strobe active after reset", $time);
        errors++;
      end
    end
  endtask

  task automatic test_forward();
    send_scan(`SCAN_PLAY);
    clear_samples();
    wait_samples(8, 10 * sample_cycles);
    for (int i = 0; i < 8; i++)
      check_sample(i, `FLASH_ADDR_W'(i / 2), (i % 2) == 1);
  endtask

  task automatic test_stop_reverse();
    send_scan(`SCAN_STOP);
    clear_samples();
    repeat (3 * sample_cycles) @(posedge CLK_50M);
    checks++;
    assert (sample_q.size() == 0)
    else
    begin
      $display("Error at time %0t: %0d samples sent while stopped", $time, sample_q.size());
      errors++;
    end
    send_scan(`SCAN_PLAY);
    clear_samples();
    wait_samples(1, 2 * sample_cycles);
    check_sample(0, 23'd4, 1'b0);
    // Word 4 finishes before the address counts down
    send_scan(`SCAN_BACKWARD);
    wait_samples(5, 6 * sample_cycles);
    check_sample(1, 23'd4, 1'b1);
    check_sample(2, 23'd3, 1'b1);
    check_sample(3, 23'd3, 1'b0);
    check_sample(4, 23'd2, 1'b1);
    send_scan(`SCAN_RESTART);
    clear_samples();
    wait_samples(3, 4 * sample_cycles);
    check_sample(0, `FLASH_LAST_WORD, 1'b1);
    check_sample(1, `FLASH_LAST_WORD, 1'b0);
    check_sample(2, `FLASH_LAST_WORD - 1'b1, 1'b1);
    send_scan(`SCAN_STOP);
  endtask

  task automatic test_speed();
    @(posedge CLK_50M);
    key_n <= 3'b110;
    wait_display(`DIV_DEFAULT, 1'b0, 3 * key_cycles);
    @(posedge CLK_50M);
    key_n <= 3'b111;
    repeat (2 * key_cycles) @(posedge CLK_50M);
    check_display(`DIV_DEFAULT - `SPEED_STEP);
    @(posedge CLK_50M);
    key_n <= 3'b101;
    wait_display(`DIV_MAX, 1'b1, 200 * key_cycles);
    repeat (5 * key_cycles) @(posedge CLK_50M);
    check_display(`DIV_MAX);
    @(posedge CLK_50M);
    key_n <= 3'b011;
    wait_display(`DIV_DEFAULT, 1'b1, 3 * key_cycles);
    @(posedge CLK_50M);
    key_n <= 3'b111;
    repeat (2 * key_cycles) @(posedge CLK_50M);
    check_display(`DIV_DEFAULT);
  endtask

  task automatic test_min_speed();
    int gap;
    @(posedge CLK_50M);
    key_n <= 3'b110;
    wait_display(`DIV_MIN, 1'b1, 80 * key_cycles);
    repeat (3 * key_cycles) @(posedge CLK_50M);
    check_display(`DIV_MIN);
    @(posedge CLK_50M);
    key_n <= 3'b111;
    send_scan(`SCAN_FORWARD);
    send_scan(`SCAN_RESTART);
    send_scan(`SCAN_PLAY);
    clear_samples();
    wait_samples(16, 40 * min_cycles);
    for (int i = 0; i < 16; i++)
      check_sample(i, `FLASH_ADDR_W'(i / 2), (i % 2) == 1);
    for (int i = 1; i < time_q.size(); i++)
    begin
      gap = time_q[i] - time_q[i-1];
      checks++;
      assert (gap >= min_cycles)
      else
      begin
        $display("Mismatch at time %0t: gap before sample %0d expected at least %0d got %0d",
                 $time, i, min_cycles, gap);
        errors++;
      end
    end
    send_scan(`SCAN_STOP);
  endtask

  initial
  begin
    repeat (2) @(posedge CLK_50M);
    rst <= 1'b0;
    repeat (2) @(posedge CLK_50M);
    test_reset();
    test_forward();
    test_stop_reverse();
    test_speed();
    test_min_speed();
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

  initial
  begin
    repeat (watchdog_cycles) @(posedge CLK_50M);
    $display("Watchdog expired after %0d cycles, tests did not finish", watchdog_cycles);
    $display("Checks: %0d  Errors: %0d", checks, errors + 1);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: ipod_top.f
+incdir+common
common/ipod_pkg.sv
player/player_control.sv
player/sample_fetcher.sv
verilog/speed_control.sv
verilog/hex_display.sv
verilog/ipod_top.sv
verification/ipod_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module ipod_tb -Mdir obj_dir -f ipod_top.f \
  && ./obj_dir/Vipod_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "Simulation reported errors"; exit 1; } \
  || echo "Simulation clean"
exit 0
